//--- build.f
src/saturnPkg.sv
src/cpuBusMux.sv
src/periphBusMux.sv
src/cdBusGlue.sv
src/resetDebugCtrl.sv
src/saturnGlue.sv
verif/saturnGlueTb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= saturnGlueTb
RTL_TOP    ?= saturnGlue
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= src/saturnPkg.sv src/cpuBusMux.sv src/periphBusMux.sv \
              src/cdBusGlue.sv src/resetDebugCtrl.sv src/saturnGlue.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/glueTests.txt
# kind sel ctl exp flag, all hex; kind 0 main bus, 1 A-bus, 2 B-bus, 3 CD sub-bus,
# 4 CD enables, 5 memory reset, 6 debug event; sel and ctl pack the inputs MSB first
5 3 0 0 0
0 0F 3 0 1
0 0E 3 0 1
0 1E 3 1 1
0 1F 3 2 1
0 17 1 0 0
0 1E 1 1 1
0 1F 1 2 1
0 1B 2 0 0
1 3 3 0 1
1 5 1 0 0
1 6 2 1 0
1 7 3 2 1
2 0 0 0 0
2 4 0 1 0
2 6 0 2 0
2 7 0 3 0
3 6 7 0 0
3 9 6 1 0
3 3 3 0 1
3 D 5 1 1
4 9 0 4 5
5 2 0 0 1
6 1 1 0 0
6 0 1 0 1
6 2 0 0 0
6 3 0 0 1
6 1 1 0 1
6 0 0 0 0

//--- verif/saturnGlueTb.sv
`timescale 1ns/1ps

module saturnGlueTb;

	import saturnPkg::*;

	localparam int waitLimit = 20;

	logic CLK = 1'b0;
	logic RST_N;
	logic ramhCsN, dramCeN, romCeN, sramCeN, smpcCeN, memWaitN, ctrlWaitN, cpuWaitN;
	cpuDataT memDi, scuDo, cpuDi;
	smpcDataT smpcDo;
	logic aCs0N, aCs1N, aCs2N, cartAWaitN, cdAWaitN, aWaitN, bCs1N, bCs2N, bCssN;
	periphDataT cartDo, cdDo, vdp1Do, vdp2Do, scspDo, aDi, bDi;
	logic cdCe, sCs1N, sWrlN, sWrhN, sRdN, dack0, dack1, cdRamRdy;
	logic shCeR, shCeF, cdRamRd, cdRamCs, sWaitN;
	cdAddrT sA;
	periphDataT shDo, ygrSdo, cdRamQ, sDi, cdRamD;
	cdRamAddrT cdRamA;
	logic [1:0] cdRamWe;
	logic smpcCe, drawStart, cmdEnd, dbgBreak, dbgRun, dbgPause, memResN, pause;

	logic [31:0] kind, sel, ctl, expSrc, flag; // Current vector columns
	logic [15:0] lfsr = 16'd85;
	logic brkNow = 1'b0;

	saturnGlue dut_i (.*);

	always #4 CLK = ~CLK;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkCpuData(input string name, input cpuDataT expected,
			input cpuDataT actual);
		if (actual !== expected) begin
			abortRun($sformatf("FAIL %0t %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkPeriph(input string name, input periphDataT expected,
			input periphDataT actual);
		if (actual !== expected) begin
			abortRun($sformatf("FAIL %0t %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkRamAddr(input string name, input cdRamAddrT expected,
			input cdRamAddrT actual);
		if (actual !== expected) begin
			abortRun($sformatf("FAIL %0t %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abortRun($sformatf("FAIL %0t %s expected %b actual %b",
				$time, name, expected, actual));
		end
	endtask

	task automatic nextDriveSlot();
		@(posedge CLK);
		#1;
	endtask

	task automatic randomizeData();
		memDi  = cpuDataT'(randBits(32));
		scuDo  = cpuDataT'(randBits(32));
		smpcDo = smpcDataT'(randBits(8));
		cartDo = periphDataT'(randBits(16));
		cdDo   = periphDataT'(randBits(16));
		vdp1Do = periphDataT'(randBits(16));
		vdp2Do = periphDataT'(randBits(16));
		scspDo = periphDataT'(randBits(16));
		shDo   = periphDataT'(randBits(16));
		ygrSdo = periphDataT'(randBits(16));
		cdRamQ = periphDataT'(randBits(16));
		sA     = cdAddrT'(randBits(21));
	endtask

	task automatic initInputs();
		{ramhCsN, dramCeN, romCeN, sramCeN, smpcCeN} = '1;
		{memWaitN, ctrlWaitN} = '1;
		{aCs0N, aCs1N, aCs2N, bCs1N, bCs2N, bCssN} = '1;
		{cartAWaitN, cdAWaitN} = '1;
		{sCs1N, sWrlN, sWrhN, sRdN, dack0, dack1, cdRamRdy} = '1;
		cdCe = 1'b0;
		{smpcCe, drawStart, cmdEnd, dbgBreak, dbgRun, dbgPause} = '0;
		randomizeData();
	endtask

	task automatic cpuBusAccess();
		cpuDataT expected;
		nextDriveSlot();
		randomizeData();
		{ramhCsN, dramCeN, romCeN, sramCeN, smpcCeN} = sel[4:0];
		{memWaitN, ctrlWaitN} = ctl[1:0];
		case (expSrc)
			0: expected = memDi;
			1: expected = {smpcDo, smpcDo, smpcDo, smpcDo}; // Byte on every lane
			default: expected = scuDo;
		endcase
		@(negedge CLK);
		checkCpuData("cpuDi", expected, cpuDi);
		checkBit("cpuWaitN", flag[0], cpuWaitN);
	endtask

	task automatic aBusAccess();
		periphDataT expected;
		nextDriveSlot();
		randomizeData();
		{aCs0N, aCs1N, aCs2N} = sel[2:0];
		{cartAWaitN, cdAWaitN} = ctl[1:0];
		case (expSrc)
			0: expected = cartDo;
			1: expected = cdDo;
			default: expected = 16'hffff;
		endcase
		@(negedge CLK);
		checkPeriph("aDi", expected, aDi);
		checkBit("aWaitN", flag[0], aWaitN);
	endtask

	task automatic bBusAccess();
		periphDataT expected;
		nextDriveSlot();
		randomizeData();
		{bCs1N, bCs2N, bCssN} = sel[2:0];
		case (expSrc)
			0: expected = vdp1Do;
			1: expected = vdp2Do;
			2: expected = scspDo;
			default: expected = 16'h0000;
		endcase
		@(negedge CLK);
		checkPeriph("bDi", expected, bDi);
	endtask

	task automatic subBusAccess();
		nextDriveSlot();
		randomizeData();
		{sCs1N, sWrhN, sWrlN, sRdN} = sel[3:0];
		{dack0, dack1, cdRamRdy} = ctl[2:0];
		@(negedge CLK);
		checkPeriph("sDi", (expSrc == 0) ? cdRamQ : ygrSdo, sDi);
		checkPeriph("cdRamD", flag[0] ? ygrSdo : shDo, cdRamD);
		checkBit("cdRamCs", ~sCs1N, cdRamCs);
		checkBit("cdRamWe[1]", ~sWrhN, cdRamWe[1]);
		checkBit("cdRamWe[0]", ~sWrlN, cdRamWe[0]);
		checkBit("cdRamRd", ~sRdN, cdRamRd);
		checkBit("sWaitN", cdRamRdy, sWaitN);
		checkRamAddr("cdRamA", sA[17:0], cdRamA);
	endtask

	task automatic countCdEnables(input int pulses, input int expRise, input int expFall);
		int rise;
		int fall;
		int gap;
		logic lastRise;
		rise = 0;
		fall = 0;
		lastRise = 1'b0;
		for (int p = 0; p < pulses; p++) begin
			nextDriveSlot();
			cdCe = 1'b1;
			@(negedge CLK);
			checkBit("shCeF", ~shCeR, shCeF); // Exactly one enable per cdCe
			if (p > 0) checkBit("shCeR", ~lastRise, shCeR);
			lastRise = shCeR;
			if (shCeR) rise++;
			else fall++;
			gap = int'(randBits(1)) + 1;
			nextDriveSlot();
			cdCe = 1'b0;
			repeat (gap) begin
				@(negedge CLK);
				checkBit("shCeR", 1'b0, shCeR);
				checkBit("shCeF", 1'b0, shCeF);
			end
		end
		checkPeriph("shCeR count", periphDataT'(expRise), periphDataT'(rise));
		checkPeriph("shCeF count", periphDataT'(expFall), periphDataT'(fall));
	endtask

	task automatic releaseMemReset();
		int cycles;
		@(negedge CLK);
		checkBit("memResN", flag[0], memResN);
		nextDriveSlot();
		smpcCe = 1'b1;
		nextDriveSlot();
		smpcCe = 1'b0;
		cycles = 0;
		while (memResN !== 1'b1) begin
			@(negedge CLK);
			cycles++;
			if (cycles > waitLimit) abortRun("memResN stayed low after smpcCe");
		end
		repeat (sel) begin
			@(negedge CLK);
			checkBit("memResN", 1'b1, memResN);
		end
	endtask

	task automatic debugEvent();
		nextDriveSlot();
		dbgBreak = ctl[0];
		case (sel)
			0: drawStart = 1'b1;
			1: cmdEnd = 1'b1;
			2: dbgRun = 1'b1;
			default: dbgPause = 1'b1;
		endcase
		@(negedge CLK);
		checkBit("pause", (sel == 3) ? flag[0] : brkNow, pause); // Before the edge
		nextDriveSlot();
		{drawStart, cmdEnd, dbgRun, dbgPause} = '0;
		if (sel != 3) brkNow = flag[0];
		@(negedge CLK);
		checkBit("pause", brkNow, pause);
	endtask

	task automatic dispatchVector();
		case (kind)
			0: cpuBusAccess();
			1: aBusAccess();
			2: bBusAccess();
			3: subBusAccess();
			4: countCdEnables(sel, expSrc, flag);
			5: releaseMemReset();
			6: debugEvent();
			default: abortRun("unknown vector kind in test file");
		endcase
	endtask

	initial begin
		int fd;
		int nRead;
		int nVec;
		string line;
		initInputs();
		RST_N = 1'b0;
		repeat (3) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		@(negedge CLK);
		checkBit("memResN", 1'b0, memResN);
		checkBit("pause", 1'b0, pause);
		checkBit("shCeR", 1'b0, shCeR);
		fd = $fopen("verif/glueTests.txt", "r");
		if (fd == 0) abortRun("cannot open verif/glueTests.txt");
		nVec = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Skip comments and blank lines
			if (line.len() > 1 && line[0] != "#") begin
				nRead = $sscanf(line, "%h %h %h %h %h", kind, sel, ctl, expSrc, flag);
				if (nRead != 5) abortRun("malformed line in test file");
				dispatchVector();
				nVec++;
			end
		end
		$fclose(fd);
		if (nVec == 0) begin
			abortRun("no vectors found in test file");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

//--- src/saturnGlue.sv
`timescale 1ns/1ps

module saturnGlue (
	input  logic                  CLK,
	input  logic                  RST_N,

	input  logic                  ramhCsN,
	input  logic                  dramCeN,
	input  logic                  romCeN,
	input  logic                  sramCeN,
	input  logic                  smpcCeN,
	input  saturnPkg::cpuDataT    memDi,
	input  saturnPkg::cpuDataT    scuDo,
	input  saturnPkg::smpcDataT   smpcDo,
	input  logic                  memWaitN,
	input  logic                  ctrlWaitN,
	output saturnPkg::cpuDataT    cpuDi,
	output logic                  cpuWaitN,

	input  logic                  aCs0N,
	input  logic                  aCs1N,
	input  logic                  aCs2N,
	input  saturnPkg::periphDataT cartDo,
	input  saturnPkg::periphDataT cdDo,
	input  logic                  cartAWaitN,
	input  logic                  cdAWaitN,
	input  logic                  bCs1N,
	input  logic                  bCs2N,
	input  logic                  bCssN,
	input  saturnPkg::periphDataT vdp1Do,
	input  saturnPkg::periphDataT vdp2Do,
	input  saturnPkg::periphDataT scspDo,
	output saturnPkg::periphDataT aDi,
	output saturnPkg::periphDataT bDi,
	output logic                  aWaitN,

	input  logic                  cdCe,
	input  saturnPkg::cdAddrT     sA,
	input  saturnPkg::periphDataT shDo,
	input  saturnPkg::periphDataT ygrSdo,
	input  saturnPkg::periphDataT cdRamQ,
	input  logic                  sCs1N,
	input  logic                  sWrlN,
	input  logic                  sWrhN,
	input  logic                  sRdN,
	input  logic                  dack0,
	input  logic                  dack1,
	input  logic                  cdRamRdy,
	output logic                  shCeR,
	output logic                  shCeF,
	output saturnPkg::periphDataT sDi,
	output saturnPkg::cdRamAddrT  cdRamA,
	output saturnPkg::periphDataT cdRamD,
	output logic [1:0]            cdRamWe,
	output logic                  cdRamRd,
	output logic                  cdRamCs,
	output logic                  sWaitN,

	input  logic                  smpcCe,
	input  logic                  drawStart,
	input  logic                  cmdEnd,
	input  logic                  dbgBreak,
	input  logic                  dbgRun,
	input  logic                  dbgPause,
	output logic                  memResN,
	output logic                  pause
);

	// Main CPU bus
	cpuBusMux cpuBus_i (
		.ramhCsN   (ramhCsN),
		.dramCeN   (dramCeN),
		.romCeN    (romCeN),
		.sramCeN   (sramCeN),
		.smpcCeN   (smpcCeN),
		.memDi     (memDi),
		.scuDo     (scuDo),
		.smpcDo    (smpcDo),
		.memWaitN  (memWaitN),
		.ctrlWaitN (ctrlWaitN),
		.cpuDi     (cpuDi),
		.cpuWaitN  (cpuWaitN)
	);

	periphBusMux periphBus_i (
		.aCs0N      (aCs0N),
		.aCs1N      (aCs1N),
		.aCs2N      (aCs2N),
		.cartDo     (cartDo),
		.cdDo       (cdDo),
		.cartAWaitN (cartAWaitN),
		.cdAWaitN   (cdAWaitN),
		.bCs1N      (bCs1N),
		.bCs2N      (bCs2N),
		.bCssN      (bCssN),
		.vdp1Do     (vdp1Do),
		.vdp2Do     (vdp2Do),
		.scspDo     (scspDo),
		.aDi        (aDi),
		.bDi        (bDi),
		.aWaitN     (aWaitN)
	);

	// CD block sub-CPU side
	cdBusGlue cdGlue_i (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.cdCe     (cdCe),
		.sA       (sA),
		.shDo     (shDo),
		.ygrSdo   (ygrSdo),
		.cdRamQ   (cdRamQ),
		.sCs1N    (sCs1N),
		.sWrlN    (sWrlN),
		.sWrhN    (sWrhN),
		.sRdN     (sRdN),
		.dack0    (dack0),
		.dack1    (dack1),
		.cdRamRdy (cdRamRdy),
		.shCeR    (shCeR),
		.shCeF    (shCeF),
		.sDi      (sDi),
		.cdRamA   (cdRamA),
		.cdRamD   (cdRamD),
		.cdRamWe  (cdRamWe),
		.cdRamRd  (cdRamRd),
		.cdRamCs  (cdRamCs),
		.sWaitN   (sWaitN)
	);

	resetDebugCtrl resetDebug_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.smpcCe    (smpcCe),
		.drawStart (drawStart),
		.cmdEnd    (cmdEnd),
		.dbgBreak  (dbgBreak),
		.dbgRun    (dbgRun),
		.dbgPause  (dbgPause),
		.memResN   (memResN),
		.pause     (pause)
	);

endmodule

//--- src/resetDebugCtrl.sv
`timescale 1ns/1ps

module resetDebugCtrl (
	input  logic CLK,
	input  logic RST_N,
	input  logic smpcCe,
	input  logic drawStart,
	input  logic cmdEnd,
	input  logic dbgBreak,
	input  logic dbgRun,
	input  logic dbgPause,
	output logic memResN,
	output logic pause
);

	logic brk;
	logic drawSeen;

	// Memory held in reset until the SMPC starts ticking
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			memResN <= 1'b0;
		end else if (smpcCe) begin
			memResN <= 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			brk      <= 1'b0;
			drawSeen <= 1'b0;
		end else begin
			if (drawStart) begin
				brk      <= dbgBreak;
				drawSeen <= 1'b1;
			end else if (cmdEnd && drawSeen) begin
				brk <= dbgBreak; // Step per VDP1 command
			end else if (dbgRun) begin
				brk <= 1'b0;
			end
		end
	end

	// Manual pause acts at once
	assign pause = dbgPause | brk;

endmodule

//--- src/cdBusGlue.sv
`timescale 1ns/1ps

module cdBusGlue (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  cdCe,
	input  saturnPkg::cdAddrT     sA,
	input  saturnPkg::periphDataT shDo,
	input  saturnPkg::periphDataT ygrSdo,
	input  saturnPkg::periphDataT cdRamQ,
	input  logic                  sCs1N,
	input  logic                  sWrlN,
	input  logic                  sWrhN,
	input  logic                  sRdN,
	input  logic                  dack0,
	input  logic                  dack1,
	input  logic                  cdRamRdy,
	output logic                  shCeR,
	output logic                  shCeF,
	output saturnPkg::periphDataT sDi,
	output saturnPkg::cdRamAddrT  cdRamA,
	output saturnPkg::periphDataT cdRamD,
	output logic [1:0]            cdRamWe,
	output logic                  cdRamRd,
	output logic                  cdRamCs,
	output logic                  sWaitN
);

	import saturnPkg::*;

	logic shClk;
	logic dmaAck;

	// Half-rate sub-CPU clock phase
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			shClk <= 1'b0;
		end else if (cdCe) begin
			shClk <= ~shClk;
		end
	end

	assign shCeR = shClk & cdCe;
	assign shCeF = ~shClk & cdCe; // First enable after reset is a fall

	// CD RAM hangs off sub-bus CS1
	assign cdRamCs = ~sCs1N;
	assign cdRamWe = ~{sWrhN, sWrlN}; // Upper byte in bit 1
	assign cdRamRd = ~sRdN;
	assign cdRamA  = sA[cdRamAddrW-1:0];

	always_comb begin
		if (!sCs1N) begin
			sDi = cdRamQ;
		end else begin
			sDi = ygrSdo; // YGR019 registers and FIFO
		end
	end

	// During DMA the YGR019 drives the RAM data directly
	assign dmaAck = !dack0 || !dack1;

	always_comb begin
		if (dmaAck) begin
			cdRamD = ygrSdo;
		end else begin
			cdRamD = shDo;
		end
	end

	assign sWaitN = cdRamRdy;

endmodule

//--- src/periphBusMux.sv
`timescale 1ns/1ps

module periphBusMux (
	input  logic                  aCs0N,
	input  logic                  aCs1N,
	input  logic                  aCs2N,
	input  saturnPkg::periphDataT cartDo,
	input  saturnPkg::periphDataT cdDo,
	input  logic                  cartAWaitN,
	input  logic                  cdAWaitN,
	input  logic                  bCs1N,
	input  logic                  bCs2N,
	input  logic                  bCssN,
	input  saturnPkg::periphDataT vdp1Do,
	input  saturnPkg::periphDataT vdp2Do,
	input  saturnPkg::periphDataT scspDo,
	output saturnPkg::periphDataT aDi,
	output saturnPkg::periphDataT bDi,
	output logic                  aWaitN
);

	import saturnPkg::*;

	aSrcE aSrc;
	bSrcE bSrc;

	// A-bus: cart areas 0/1, CD block on area 2
	always_comb begin
		if (!aCs0N || !aCs1N) begin
			aSrc = aCart;
		end else if (!aCs2N) begin
			aSrc = aCd;
		end else begin
			aSrc = aNone;
		end
	end

	always_comb begin
		case (aSrc)
			aCart:   aDi = cartDo;
			aCd:     aDi = cdDo;
			default: aDi = aBusIdle;
		endcase
	end

	assign aWaitN = cdAWaitN & cartAWaitN;

	// B-bus priority VDP1, VDP2, SCSP
	always_comb begin
		if (!bCs1N) begin
			bSrc = bVdp1;
		end else if (!bCs2N) begin
			bSrc = bVdp2;
		end else if (!bCssN) begin
			bSrc = bScsp;
		end else begin
			bSrc = bNone;
		end
	end

	always_comb begin
		case (bSrc)
			bVdp1:   bDi = vdp1Do;
			bVdp2:   bDi = vdp2Do;
			bScsp:   bDi = scspDo;
			default: bDi = bBusIdle;
		endcase
	end

endmodule

//--- src/cpuBusMux.sv
`timescale 1ns/1ps

module cpuBusMux (
	input  logic                ramhCsN,
	input  logic                dramCeN,
	input  logic                romCeN,
	input  logic                sramCeN,
	input  logic                smpcCeN,
	input  saturnPkg::cpuDataT  memDi,
	input  saturnPkg::cpuDataT  scuDo,
	input  saturnPkg::smpcDataT smpcDo,
	input  logic                memWaitN,
	input  logic                ctrlWaitN,
	output saturnPkg::cpuDataT  cpuDi,
	output logic                cpuWaitN
);

	import saturnPkg::*;

	logic   memSel;
	cpuSrcE src;

	// High RAM, low RAM, BIOS ROM or backup SRAM
	assign memSel = !ramhCsN || !dramCeN || !romCeN || !sramCeN;

	always_comb begin
		if (memSel) begin
			src = srcMem;
		end else if (!smpcCeN) begin
			src = srcSmpc;
		end else begin
			src = srcScu; // Everything else decodes in the SCU
		end
	end

	always_comb begin
		case (src)
			srcMem: begin
				cpuDi = memDi;
			end
			srcSmpc: begin
				cpuDi = {smpcLanes{smpcDo}};
			end
			default: begin
				cpuDi = scuDo;
			end
		endcase
	end

	// External memory wait only counts on memory cycles
	assign cpuWaitN = ctrlWaitN & (memWaitN | !memSel);

endmodule

//--- src/saturnPkg.sv
package saturnPkg;

	// Bus widths
	localparam int cpuAddrW    = 25;
	localparam int cpuDataW    = 32;
	localparam int smpcDataW   = 8;
	localparam int periphDataW = 16;
	localparam int cdAddrW     = 21;
	localparam int cdRamAddrW  = 18; // CD RAM sits in the low part of the sub-bus

	typedef logic [cpuAddrW-1:0]    cpuAddrT;
	typedef logic [cpuDataW-1:0]    cpuDataT;
	typedef logic [smpcDataW-1:0]   smpcDataT;
	typedef logic [periphDataW-1:0] periphDataT;
	typedef logic [cdAddrW-1:0]     cdAddrT;
	typedef logic [cdRamAddrW-1:0]  cdRamAddrT;

	// SMPC byte is mirrored on every lane of the main bus
	localparam int smpcLanes = cpuDataW / smpcDataW;

	// Open bus values
	localparam periphDataT aBusIdle = '1; // A-bus floats high
	localparam periphDataT bBusIdle = '0;

	typedef enum logic [1:0] {
		srcMem,
		srcSmpc,
		srcScu
	} cpuSrcE;

	typedef enum logic [1:0] {
		aCart,
		aCd,
		aNone
	} aSrcE;

	typedef enum logic [1:0] {
		bVdp1,
		bVdp2,
		bScsp,
		bNone
	} bSrcE;

endpackage
